/* src/stream_macros.svh */
`ifndef STREAM_MACROS_SVH
`define STREAM_MACROS_SVH

// stream link widths
`define STREAM_DATA_WIDTH 8
`define FIFO_ADDR_WIDTH   4  // 16 words

// frame record widths
`define LEN_WIDTH 16
`define CNT_WIDTH 16

`endif

/* src/stream_pkg.sv */
`include "stream_macros.svh"

package stream_pkg;

  // --------------------
  // datapath types
  typedef logic [`STREAM_DATA_WIDTH-1:0] word_t;
  typedef logic [`LEN_WIDTH-1:0]         len_t;   // beats per frame
  typedef logic [15:0]                   sum_t;   // ones' complement sum
  typedef logic [`CNT_WIDTH-1:0]         cnt_t;

  // --------------------
  // frame controller state
  typedef enum logic {
    idle,      // waiting for first beat
    in_frame
  } frame_state_t;

endpackage

/* src/axis_stream_if.sv */
`timescale 1ns/1ns

interface axis_stream_if;
  import stream_pkg::*;

  word_t tdata;
  logic  tvalid;
  logic  tready;
  logic  tlast;
  logic  tuser;  // error flag for the beat

  modport source (
    output tdata, tvalid, tlast, tuser,
    input  tready
  );

  modport sink (
    input  tdata, tvalid, tlast, tuser,
    output tready
  );

endinterface

/* src/frame_beat_if.sv */
`timescale 1ns/1ns

// one event per transferred beat
interface frame_beat_if;
  import stream_pkg::*;

  logic  beat;   // single-cycle strobe
  logic  first;
  logic  last;
  logic  err;
  word_t data;

  modport source (
    output beat, first, last, err, data
  );

  modport sink (
    input beat, first, last, err, data
  );

endinterface

/* src/axis_async_fifo.sv */
`timescale 1ns/1ns
`include "stream_macros.svh"

module axis_async_fifo #(
  parameter int ADDR_WIDTH = `FIFO_ADDR_WIDTH
) (
  input  logic               output_clk,
  input  logic               output_rst_sync3,
  input  logic               input_clk,
  input  stream_pkg::word_t  input_axis_tdata,
  input  logic               input_axis_tvalid,
  input  logic               input_axis_tlast,
  input  logic               input_axis_tuser,
  output logic               input_axis_tready,
  axis_stream_if.source      m
);
  import stream_pkg::*;

  localparam int ENTRY_WIDTH = $bits(word_t) + 2;  // tlast, tuser, tdata

  logic [ENTRY_WIDTH-1:0] mem [2**ADDR_WIDTH];
  logic [ENTRY_WIDTH-1:0] data_out_reg;
  logic                   tvalid_reg;

  logic [ADDR_WIDTH:0] wr_ptr, wr_ptr_next, wr_ptr_gray;
  logic [ADDR_WIDTH:0] rd_ptr, rd_ptr_next, rd_ptr_gray;
  logic [ADDR_WIDTH:0] wr_ptr_gray_sync1, wr_ptr_gray_sync2;
  logic [ADDR_WIDTH:0] rd_ptr_gray_sync1, rd_ptr_gray_sync2;

  // power up in reset until the chain has seen output_rst_sync3
  logic input_rst_sync1 = 1'b1;
  logic input_rst_sync2 = 1'b1;
  logic input_rst_sync3 = 1'b1;

  logic full, empty, write, read;

  // full when the two top Gray bits differ and the rest match
  assign full  = wr_ptr_gray == {~rd_ptr_gray_sync2[ADDR_WIDTH:ADDR_WIDTH-1],
                                 rd_ptr_gray_sync2[ADDR_WIDTH-2:0]};
  assign empty = rd_ptr_gray == wr_ptr_gray_sync2;

  assign input_axis_tready = ~full & ~input_rst_sync3;
  assign write = input_axis_tvalid & input_axis_tready;
  assign read  = ~empty & (m.tready | ~tvalid_reg);  // refill when empty or accepted

  assign wr_ptr_next = wr_ptr + 1'b1;
  assign rd_ptr_next = rd_ptr + 1'b1;

  // --------------------
  // input domain
  always_ff @(posedge input_clk) begin
    input_rst_sync1 <= output_rst_sync3;
    input_rst_sync2 <= input_rst_sync1;
    input_rst_sync3 <= input_rst_sync2;
  end

  always_ff @(posedge input_clk) begin
    if (input_rst_sync3) begin
      wr_ptr      <= '0;
      wr_ptr_gray <= '0;
    end else if (write) begin
      wr_ptr      <= wr_ptr_next;
      wr_ptr_gray <= wr_ptr_next ^ (wr_ptr_next >> 1);
    end
  end

  always_ff @(posedge input_clk) begin
    if (write)
      mem[wr_ptr[ADDR_WIDTH-1:0]] <= {input_axis_tlast, input_axis_tuser, input_axis_tdata};
  end

  always_ff @(posedge input_clk) begin
    if (input_rst_sync3) begin
      rd_ptr_gray_sync1 <= '0;
      rd_ptr_gray_sync2 <= '0;
    end else begin
      rd_ptr_gray_sync1 <= rd_ptr_gray;
      rd_ptr_gray_sync2 <= rd_ptr_gray_sync1;
    end
  end

  // --------------------
  // output domain
  always_ff @(posedge output_clk) begin
    if (output_rst_sync3) begin
      wr_ptr_gray_sync1 <= '0;
      wr_ptr_gray_sync2 <= '0;
    end else begin
      wr_ptr_gray_sync1 <= wr_ptr_gray;
      wr_ptr_gray_sync2 <= wr_ptr_gray_sync1;
    end
  end

  always_ff @(posedge output_clk) begin
    if (output_rst_sync3) begin
      rd_ptr      <= '0;
      rd_ptr_gray <= '0;
      tvalid_reg  <= 1'b0;
    end else begin
      if (read) begin
        rd_ptr      <= rd_ptr_next;
        rd_ptr_gray <= rd_ptr_next ^ (rd_ptr_next >> 1);
      end
      if (m.tready | ~tvalid_reg)
        tvalid_reg <= ~empty;
    end
  end

  always_ff @(posedge output_clk) begin
    if (read)
      data_out_reg <= mem[rd_ptr[ADDR_WIDTH-1:0]];
  end

  assign {m.tlast, m.tuser, m.tdata} = data_out_reg;
  assign m.tvalid = tvalid_reg;

endmodule

/* src/frame_ctrl.sv */
`timescale 1ns/1ns

module frame_ctrl (
  input  logic               output_clk,
  input  logic               output_rst_sync3,
  axis_stream_if.sink        s,
  output stream_pkg::word_t  output_axis_tdata,
  output logic               output_axis_tvalid,
  output logic               output_axis_tlast,
  output logic               output_axis_tuser,
  input  logic               output_axis_tready,
  frame_beat_if.source       ev
);
  import stream_pkg::*;

  frame_state_t state;
  logic         xfer;

  // --------------------
  // stream pass-through
  assign output_axis_tdata  = s.tdata;
  assign output_axis_tvalid = s.tvalid;
  assign output_axis_tlast  = s.tlast;
  assign output_axis_tuser  = s.tuser;
  assign s.tready           = output_axis_tready;

  assign xfer = s.tvalid & s.tready;

  // --------------------
  // frame tracking
  always_ff @(posedge output_clk) begin
    if (output_rst_sync3) begin
      state <= idle;
    end else if (xfer) begin
      if (s.tlast)
        state <= idle;
      else
        state <= in_frame;
    end
  end

  // beat events for the datapath blocks
  assign ev.beat  = xfer;
  assign ev.first = xfer & (state == idle);
  assign ev.last  = xfer & s.tlast;
  assign ev.err   = s.tuser;
  assign ev.data  = s.tdata;

endmodule

/* src/frame_checksum.sv */
`timescale 1ns/1ns

module frame_checksum (
  input  logic              output_clk,
  input  logic              output_rst_sync3,
  frame_beat_if.sink        ev,
  output stream_pkg::sum_t  frame_sum
);
  import stream_pkg::*;

  sum_t                 acc;
  sum_t                 base;
  logic [$bits(sum_t):0] raw;   // one extra bit for the carry
  sum_t                 acc_next;

  assign base     = ev.first ? '0 : acc;
  assign raw      = {1'b0, base} + {{($bits(sum_t) + 1 - $bits(word_t)){1'b0}}, ev.data};
  assign acc_next = raw[$bits(sum_t)-1:0] + sum_t'(raw[$bits(sum_t)]);  // end-around carry

  always_ff @(posedge output_clk) begin
    if (output_rst_sync3) begin
      acc       <= '0;
      frame_sum <= '0;
    end else if (ev.beat) begin
      acc <= acc_next;
      if (ev.last)
        frame_sum <= acc_next;
    end
  end

endmodule

/* src/frame_stats.sv */
`timescale 1ns/1ns

module frame_stats (
  input  logic              output_clk,
  input  logic              output_rst_sync3,
  frame_beat_if.sink        ev,
  output logic              frame_done,
  output stream_pkg::len_t  frame_len,
  output logic              frame_err,
  output stream_pkg::cnt_t  good_count,
  output stream_pkg::cnt_t  bad_count
);
  import stream_pkg::*;

  len_t beat_cnt;
  logic err_acc;
  len_t len_next;
  logic err_next;

  // first beat restarts both running values
  assign len_next = ev.first ? len_t'(1) : beat_cnt + 1'b1;
  assign err_next = ev.first ? ev.err : (err_acc | ev.err);

  always_ff @(posedge output_clk) begin
    if (output_rst_sync3) begin
      beat_cnt   <= '0;
      err_acc    <= 1'b0;
      frame_done <= 1'b0;
      frame_len  <= '0;
      frame_err  <= 1'b0;
      good_count <= '0;
      bad_count  <= '0;
    end else begin
      frame_done <= ev.beat & ev.last;
      if (ev.beat) begin
        beat_cnt <= len_next;
        err_acc  <= err_next;
        if (ev.last) begin
          frame_len <= len_next;
          frame_err <= err_next;
          if (err_next)
            bad_count <= bad_count + 1'b1;   // wraps
          else
            good_count <= good_count + 1'b1;
        end
      end
    end
  end

endmodule

/* src/stream_bridge_top.sv */
`timescale 1ns/1ns

module stream_bridge_top (
  input  logic               output_clk,
  input  logic               output_rst_sync3,
  // input stream, input_clk domain
  input  logic               input_clk,
  input  stream_pkg::word_t  input_axis_tdata,
  input  logic               input_axis_tvalid,
  input  logic               input_axis_tlast,
  input  logic               input_axis_tuser,
  output logic               input_axis_tready,
  // output stream
  output stream_pkg::word_t  output_axis_tdata,
  output logic               output_axis_tvalid,
  output logic               output_axis_tlast,
  output logic               output_axis_tuser,
  input  logic               output_axis_tready,
  // frame record
  output logic               frame_done,
  output stream_pkg::len_t   frame_len,
  output stream_pkg::sum_t   frame_sum,
  output logic               frame_err,
  output stream_pkg::cnt_t   good_count,
  output stream_pkg::cnt_t   bad_count
);

  axis_stream_if fifo_out_if ();
  frame_beat_if  beat_if ();

  axis_async_fifo axis_async_fifo_inst (
    .output_clk        (output_clk),
    .output_rst_sync3  (output_rst_sync3),
    .input_clk         (input_clk),
    .input_axis_tdata  (input_axis_tdata),
    .input_axis_tvalid (input_axis_tvalid),
    .input_axis_tlast  (input_axis_tlast),
    .input_axis_tuser  (input_axis_tuser),
    .input_axis_tready (input_axis_tready),
    .m                 (fifo_out_if.source)
  );

  frame_ctrl frame_ctrl_inst (
    .output_clk         (output_clk),
    .output_rst_sync3   (output_rst_sync3),
    .s                  (fifo_out_if.sink),
    .output_axis_tdata  (output_axis_tdata),
    .output_axis_tvalid (output_axis_tvalid),
    .output_axis_tlast  (output_axis_tlast),
    .output_axis_tuser  (output_axis_tuser),
    .output_axis_tready (output_axis_tready),
    .ev                 (beat_if.source)
  );

  frame_checksum frame_checksum_inst (
    .output_clk       (output_clk),
    .output_rst_sync3 (output_rst_sync3),
    .ev               (beat_if.sink),
    .frame_sum        (frame_sum)
  );

  frame_stats frame_stats_inst (
    .output_clk       (output_clk),
    .output_rst_sync3 (output_rst_sync3),
    .ev               (beat_if.sink),
    .frame_done       (frame_done),
    .frame_len        (frame_len),
    .frame_err        (frame_err),
    .good_count       (good_count),
    .bad_count        (bad_count)
  );

endmodule

/* tests/stream_bridge_tb.sv */
`timescale 1ns/1ns

module stream_bridge_tb;
  import stream_pkg::*;

  logic  output_clk = 1'b0;
  logic  input_clk = 1'b0;
  logic  output_rst_sync3;
  word_t input_axis_tdata;
  logic  input_axis_tvalid, input_axis_tlast, input_axis_tuser, input_axis_tready;
  word_t output_axis_tdata;
  logic  output_axis_tvalid, output_axis_tlast, output_axis_tuser;
  logic  output_axis_tready = 1'b0;
  logic  frame_done, frame_err;
  len_t  frame_len;
  sum_t  frame_sum;
  cnt_t  good_count, bad_count;

  logic [9:0]  sb_q[$];     // sent beats {tlast, tuser, tdata}
  logic [32:0] frame_q[$];  // expected records {err, sum, len}
  integer seed = 65;
  int   errs[1:5] = '{default: 0};
  int   tests_run = 0;
  int   acc_len = 0;
  int   acc_sum = 0;
  int   good_exp = 0;
  int   bad_exp = 0;
  logic acc_err = 1'b0;
  logic hold_ready = 1'b1;  // forces output_axis_tready low
  logic aborted = 1'b0;

  initial begin
    forever #5 output_clk = ~output_clk;
  end

  initial begin
    forever #7 input_clk = ~input_clk;
  end

  stream_bridge_top stream_bridge_top_inst (.*);

  function automatic string test_name(input int id);
    case (id)
      1: return "reset state";
      2: return "beat order";
      3: return "frame record";
      4: return "frame counters";
      default: return "back-pressure";
    endcase
  endfunction

  // ones' complement add, carry wraps back into bit 0
  function automatic int ones_add(input int sum, input int b);
    int r;
    r = sum + b;
    if (r > 'hffff)
      r = (r & 'hffff) + 1;
    return r;
  endfunction

  task automatic check_value(input int id, input string what, input logic [31:0] exp,
                             input logic [31:0] act);
    assert (act === exp) else begin
      errs[id]++;
      $display("error %s (%s): expected %0h, actual %0h", test_name(id), what, exp, act);
    end
  endtask

  task automatic report_test(input int id);
    tests_run++;
    $display("test %0d %s: %0d errors", id, test_name(id), errs[id]);
  endtask

  task automatic send_beat(input word_t d, input logic l, input logic u);
    int t;
    t = 0;
    input_axis_tdata  <= d;
    input_axis_tvalid <= 1'b1;
    input_axis_tlast  <= l;
    input_axis_tuser  <= u;
    @(posedge input_clk);
    while (!input_axis_tready && t < 200) begin
      @(posedge input_clk);
      t++;
    end
    if (input_axis_tready)
      sb_q.push_back({l, u, d});
    else begin
      aborted = 1'b1;
      $display("timeout: input_axis_tready stayed low for %0d input cycles", t);
    end
  endtask

  task automatic send_frame(input int len);
    for (int i = 0; i < len && !aborted; i++)
      send_beat(word_t'($random(seed)), i == len - 1, ($random(seed) & 15) == 0);
  endtask

  task automatic drain(input string what);
    int t;
    t = 0;
    while ((sb_q.size() != 0 || frame_q.size() != 0) && t < 5000 && !aborted) begin
      @(posedge output_clk);
      t++;
    end
    if (sb_q.size() != 0 || frame_q.size() != 0) begin
      aborted = 1'b1;
      $display("timeout: %s did not come out of the DUT", what);
    end
  endtask

  // --------------------
  // output side
  always @(posedge output_clk) begin
    if (hold_ready)
      output_axis_tready <= 1'b0;
    else
      output_axis_tready <= ($random(seed) % 2) != 0;
  end

  always @(posedge output_clk) begin : check_output
    logic [9:0]  exp_beat;
    logic [32:0] rec;
    if (!output_rst_sync3 && frame_done) begin
      assert (frame_q.size() > 0) else begin
        errs[3]++;
        $display("frame_done pulsed with no complete frame sent");
      end
      if (frame_q.size() > 0) begin
        rec = frame_q.pop_front();
        check_value(3, "frame_len", rec[15:0], frame_len);
        check_value(3, "frame_sum", rec[31:16], frame_sum);
        check_value(3, "frame_err", rec[32], frame_err);
        if (rec[32])
          bad_exp++;
        else
          good_exp++;
        check_value(4, "good_count", good_exp, good_count);
        check_value(4, "bad_count", bad_exp, bad_count);
      end
    end
    if (!output_rst_sync3 && output_axis_tvalid && output_axis_tready) begin
      assert (sb_q.size() > 0) else begin
        errs[2]++;
        $display("output beat appeared with no beat sent");
      end
      if (sb_q.size() > 0) begin
        exp_beat = sb_q.pop_front();
        check_value(2, "beat", exp_beat,
                    {output_axis_tlast, output_axis_tuser, output_axis_tdata});
        acc_len++;
        acc_sum = ones_add(acc_sum, exp_beat[7:0]);
        acc_err = acc_err | exp_beat[8];
        if (exp_beat[9]) begin  // frame complete
          frame_q.push_back({acc_err, acc_sum[15:0], acc_len[15:0]});
          acc_len = 0;
          acc_sum = 0;
          acc_err = 1'b0;
        end
      end
    end
  end

  // --------------------
  // test sequence
  initial begin
    int   t;
    int   n;
    int   low;
    int   total;
    word_t d;
    output_rst_sync3  = 1'b1;
    input_axis_tdata  = '0;
    input_axis_tvalid = 1'b0;
    input_axis_tlast  = 1'b0;
    input_axis_tuser  = 1'b0;
    repeat (10) @(posedge output_clk);
    output_rst_sync3 <= 1'b0;
    @(posedge output_clk);
    check_value(1, "output_axis_tvalid", 0, output_axis_tvalid);
    check_value(1, "frame_done", 0, frame_done);
    check_value(1, "frame_err", 0, frame_err);
    check_value(1, "good_count", 0, good_count);
    check_value(1, "bad_count", 0, bad_count);
    t = 0;
    while (!input_axis_tready && t < 20) begin
      @(posedge input_clk);
      t++;
    end
    if (!input_axis_tready) begin
      aborted = 1'b1;
      $display("timeout: input_axis_tready did not rise after reset");
    end
    report_test(1);

    hold_ready <= 1'b0;
    for (int f = 0; f < 30 && !aborted; f++)
      send_frame(1 + ($unsigned($random(seed)) % 20));
    input_axis_tvalid <= 1'b0;
    drain("random frames");
    if (!aborted) begin
      report_test(2);
      report_test(3);
      report_test(4);
    end

    // stall the output and fill the FIFO with single-beat frames
    if (!aborted) begin
      hold_ready <= 1'b1;
      repeat (3) @(posedge output_clk);
      @(posedge input_clk);
      n = 0;
      low = 0;
      t = 0;
      d = word_t'($random(seed));
      input_axis_tdata  <= d;
      input_axis_tvalid <= 1'b1;
      input_axis_tlast  <= 1'b1;
      input_axis_tuser  <= 1'b0;
      while (low < 8 && t < 100) begin
        @(posedge input_clk);
        t++;
        if (input_axis_tready) begin
          sb_q.push_back({2'b10, d});
          n++;
          low = 0;
          d = word_t'($random(seed));
          input_axis_tdata <= d;
        end else
          low++;
      end
      input_axis_tvalid <= 1'b0;
      assert (low >= 8) else begin
        errs[5]++;
        $display("input_axis_tready did not fall with output_axis_tready held low");
      end
      assert (n <= 17) else begin
        errs[5]++;
        $display("error %s (accepted beats): expected 17 at most, actual %0d", test_name(5), n);
      end
      hold_ready <= 1'b0;
      drain("stored beats after release");
      if (!aborted)
        report_test(5);
    end

    total = errs[1] + errs[2] + errs[3] + errs[4] + errs[5];
    $display("tests finished %0d of 5, failed checks %0d", tests_run, total);
    if (aborted || total != 0)
      $display("Simulation finished: FAIL");
    else
      $display("Simulation finished: PASS");
    $finish;
  end

endmodule

/* list.f */
+incdir+src
src/stream_pkg.sv
src/axis_stream_if.sv
src/frame_beat_if.sv
src/axis_async_fifo.sv
src/frame_ctrl.sv
src/frame_checksum.sv
src/frame_stats.sv
src/stream_bridge_top.sv
tests/stream_bridge_tb.sv

/* Makefile */
TB = stream_bridge_tb

.PHONY: all build lint clean

all: build
	@out="$$(./obj_dir/V$(TB))"; echo "$$out"; \
	echo "$$out" | grep -q "Simulation finished: PASS"

build:
	verilator --binary --timing --assert -Wno-fatal -f list.f --top-module $(TB)

lint:
	verilator --lint-only --timing -Wall -f list.f --top-module stream_bridge_top

clean:
	rm -rf obj_dir
